//--- hw/pong_geom_pkg.sv
`default_nettype none

package pong_geom_pkg;

    typedef logic [9:0] coord_t;                // Screen coordinate, pixels or lines

    // Active display area
    localparam coord_t H_VIDEO = 10'd640;       // Horizontal active video
    localparam coord_t V_VIDEO = 10'd480;       // Vertical active lines

    // Sprite sizes
    localparam coord_t BALL_SIZE  = 10'd16;     // Side of the square ball
    localparam coord_t PDL_WIDTH  = 10'd12;     // Paddle thickness
    localparam coord_t PDL_HEIGHT = 10'd96;     // Paddle length

    // Fixed paddle columns, left edge of each sprite
    localparam coord_t PDL1_X = 10'd24;         // Left player
    localparam coord_t PDL2_X = 10'd603;        // Right player

    // Home positions, top left corner
    localparam coord_t PDL_HOME_Y  = 10'd191;   // Both paddles start centred
    localparam coord_t BALL_HOME_X = 10'd320;   // Serve column
    localparam coord_t BALL_HOME_Y = 10'd240;   // Serve row

endpackage

`default_nettype wire

//--- hw/pong_game_pkg.sv
`default_nettype none

package pong_game_pkg;

    // Game phase as seen by the display logic
    typedef enum logic [1:0] {
        STARTUP = 2'd0,                         // Title screen, waiting for a press
        PLAY    = 2'd1,                         // Serve hold or rally
        OVER    = 2'd2                          // A player reached the max score
    } phase_t;

    typedef logic [3:0] score_t;                // Per-player score, up to 15

endpackage

`default_nettype wire

//--- hw/game_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module game_ctrl #(
    parameter int SERVE_DELAY = 20,             // Cycles the ball stays hidden
    parameter int SAFE_START  = 8,              // Cycles of ignored buttons after reset
    parameter int MAX_SCORE   = 3               // Score that ends the game
) (
    input  wire                    clk_0,
    input  wire                    rst,
    input  wire                    any_button,  // OR of all presses
    input  wire                    miss_left,   // Ball touched left wall, point for p2
    input  wire                    miss_right,  // Ball touched right wall, point for p1
    output logic                   play,
    output logic                   ball_run,    // Ball visible and moving
    output pong_game_pkg::score_t  score_p1,
    output pong_game_pkg::score_t  score_p2,
    output logic                   game_over,
    output logic                   game_startup
);

    import pong_game_pkg::*;

    localparam int SAFE_W  = $clog2(SAFE_START + 1);
    localparam int SERVE_W = $clog2(SERVE_DELAY + 1);

    phase_t             phase;
    logic [SAFE_W-1:0]  safe_cnt;               // Saturates at SAFE_START
    logic [SERVE_W-1:0] serve_cnt;              // Runs only during a serve hold
    logic               safe_done;
    logic               serve_done;
    score_t             score_p1_inc;
    score_t             score_p2_inc;

    assign safe_done    = (safe_cnt == SAFE_W'(SAFE_START));
    assign serve_done   = (serve_cnt == SERVE_W'(SERVE_DELAY - 1)); // Last hidden cycle
    assign score_p1_inc = score_p1 + score_t'(1);
    assign score_p2_inc = score_p2 + score_t'(1);

    // Phase decoded straight to the status levels
    assign play         = (phase == PLAY);
    assign game_over    = (phase == OVER);
    assign game_startup = (phase == STARTUP);

    always_ff @(posedge clk_0 or negedge rst) begin
        if (!rst) begin
            phase     <= STARTUP;
            safe_cnt  <= '0;
            serve_cnt <= '0;
            ball_run  <= 1'b0;
            score_p1  <= '0;
            score_p2  <= '0;
        end else begin
            case (phase)
                STARTUP: begin
                    if (!safe_done) begin
                        safe_cnt <= safe_cnt + 1'b1;    // Button bounce from reset ignored
                    end else if (any_button) begin
                        phase     <= PLAY;
                        score_p1  <= '0;
                        score_p2  <= '0;
                        serve_cnt <= '0;
                    end
                end
                PLAY: begin
                    if (!ball_run) begin                // Serve hold
                        if (serve_done) begin
                            ball_run  <= 1'b1;
                            serve_cnt <= '0;
                        end else begin
                            serve_cnt <= serve_cnt + 1'b1;
                        end
                    end else if (miss_right) begin
                        score_p1 <= score_p1_inc;
                        ball_run <= 1'b0;               // New serve hold, or game over
                        if (score_p1_inc == score_t'(MAX_SCORE)) begin
                            phase <= OVER;
                        end
                    end else if (miss_left) begin
                        score_p2 <= score_p2_inc;
                        ball_run <= 1'b0;
                        if (score_p2_inc == score_t'(MAX_SCORE)) begin
                            phase <= OVER;
                        end
                    end
                end
                OVER: begin
                    if (any_button) begin               // Scores stay shown until here
                        phase     <= PLAY;
                        score_p1  <= '0;
                        score_p2  <= '0;
                        serve_cnt <= '0;
                    end
                end
                default: phase <= STARTUP;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/paddle_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module paddle_ctrl #(
    parameter int PDL_PSC = 2                   // Extra cycles per pixel step
) (
    input  wire                    clk_0,
    input  wire                    rst,
    input  wire                    play,        // Paddles move only in play
    input  wire                    up,          // Active low
    input  wire                    down,        // Active low
    output pong_geom_pkg::coord_t  pdl_y        // Top edge of the paddle
);

    import pong_geom_pkg::*;

    localparam int     TICK_W    = $clog2(PDL_PSC + 2);
    localparam coord_t PDL_Y_MAX = V_VIDEO - 10'd1 - PDL_HEIGHT; // Bottom edge at last line

    logic [TICK_W-1:0] tick_cnt;
    logic              move_up;
    logic              move_down;
    logic              tick;

    assign move_up   = !up && down;             // Both held cancel out
    assign move_down = !down && up;
    assign tick      = (tick_cnt == TICK_W'(PDL_PSC));

    always_ff @(posedge clk_0 or negedge rst) begin
        if (!rst) begin
            pdl_y    <= PDL_HOME_Y;
            tick_cnt <= '0;
        end else if (!play) begin
            pdl_y    <= PDL_HOME_Y;             // Recentre between games
            tick_cnt <= '0;
        end else if (move_up || move_down) begin
            if (tick) begin
                tick_cnt <= '0;
                if (move_up && pdl_y > '0) begin
                    pdl_y <= pdl_y - 10'd1;     // Stop at the top line
                end else if (move_down && pdl_y < PDL_Y_MAX) begin
                    pdl_y <= pdl_y + 10'd1;
                end
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end else begin
            tick_cnt <= '0;                     // Fresh full period on the next press
        end
    end

endmodule

`default_nettype wire

//--- hw/ball_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module ball_ctrl #(
    parameter int BALL_PSC = 1                  // Extra cycles per pixel step on each axis
) (
    input  wire                    clk_0,
    input  wire                    rst,
    input  wire                    ball_run,    // Low holds the ball at home
    input  wire pong_geom_pkg::coord_t pdl1_y,
    input  wire pong_geom_pkg::coord_t pdl2_y,
    output pong_geom_pkg::coord_t  ball_x,
    output pong_geom_pkg::coord_t  ball_y,
    output logic                   miss_left,
    output logic                   miss_right
);

    import pong_geom_pkg::*;

    localparam int     TICK_W  = $clog2(BALL_PSC + 2);
    localparam coord_t X_LIMIT = H_VIDEO - BALL_SIZE - 10'd1;  // Right wall contact
    localparam coord_t Y_LIMIT = V_VIDEO - BALL_SIZE - 10'd1;  // Bottom wall contact

    logic [TICK_W-1:0] x_cnt;
    logic [TICK_W-1:0] y_cnt;
    logic              x_tick;
    logic              y_tick;
    logic              dir_x;                   // 0 = left, 1 = right
    logic              dir_y;                   // 0 = up, 1 = down
    coord_t            ball_r;                  // Right edge column
    logic              zone_l;                  // Columns overlap left paddle
    logic              zone_r;
    logic [2:0]        touch_l;                 // {overlap, top edge, bottom edge}
    logic [2:0]        touch_r;
    logic              hit_bottom;
    logic              hit_top;

    // Vertical contact of the ball against one paddle
    function automatic logic [2:0] pdl_touch(input coord_t by, input coord_t py);
        coord_t ball_b;
        coord_t pdl_b;
        logic   overlap;
        logic   top_edge;
        logic   bot_edge;
        ball_b   = by + BALL_SIZE;
        pdl_b    = py + PDL_HEIGHT;
        overlap  = (by <= pdl_b) && (ball_b >= py);
        top_edge = (ball_b == py) || (ball_b == py + 10'd1);    // Within one row
        bot_edge = (by == pdl_b) || (by == pdl_b - 10'd1);
        return {overlap, top_edge, bot_edge};
    endfunction

    assign x_tick     = (x_cnt == TICK_W'(BALL_PSC));
    assign y_tick     = (y_cnt == TICK_W'(BALL_PSC));
    assign ball_r     = ball_x + BALL_SIZE;
    assign zone_r     = (ball_r >= PDL2_X) && (ball_x <= PDL2_X + PDL_WIDTH);
    assign zone_l     = (ball_x <= PDL1_X + PDL_WIDTH + 10'd1) && (ball_r >= PDL1_X);
    assign touch_l    = pdl_touch(ball_y, pdl1_y);
    assign touch_r    = pdl_touch(ball_y, pdl2_y);
    assign hit_bottom = (ball_y >= Y_LIMIT);
    assign hit_top    = (ball_y == '0);

    // Side wall contact, only reachable while the ball runs
    assign miss_right = (ball_x >= X_LIMIT);
    assign miss_left  = (ball_x == '0);

    always_ff @(posedge clk_0 or negedge rst) begin
        if (!rst) begin
            ball_x <= BALL_HOME_X;
            ball_y <= BALL_HOME_Y;
            x_cnt  <= '0;
            y_cnt  <= '0;
            dir_x  <= 1'b0;
            dir_y  <= 1'b0;
        end else if (!ball_run || miss_right || miss_left) begin
            ball_x <= BALL_HOME_X;              // Park for the next serve
            ball_y <= BALL_HOME_Y;
            x_cnt  <= '0;                       // Both axes restart in step
            y_cnt  <= '0;
            dir_x  <= 1'b0;                     // Serve goes up and left
            dir_y  <= 1'b0;
        end else begin
            x_cnt <= x_tick ? '0 : x_cnt + 1'b1;
            y_cnt <= y_tick ? '0 : y_cnt + 1'b1;
            if (x_tick) begin
                ball_x <= dir_x ? ball_x + 10'd1 : ball_x - 10'd1;
            end
            if (y_tick) begin
                ball_y <= dir_y ? ball_y + 10'd1 : ball_y - 10'd1;
            end
            // Collisions override the step on the axis they touch
            if (hit_bottom) begin
                dir_y  <= 1'b0;
                ball_y <= ball_y - 10'd1;       // Nudge off the wall
            end else if (hit_top) begin
                dir_y  <= 1'b1;
                ball_y <= ball_y + 10'd1;
            end else if (zone_r && touch_r[2]) begin
                if (touch_r[0]) begin           // Under the paddle
                    dir_y  <= 1'b1;
                    ball_y <= ball_y + 10'd1;
                end else if (touch_r[1]) begin  // On top of the paddle
                    dir_y  <= 1'b0;
                    ball_y <= ball_y - 10'd1;
                end else begin                  // Face hit, send it back left
                    dir_x  <= 1'b0;
                    ball_x <= ball_x - 10'd1;
                end
            end else if (zone_l && touch_l[2]) begin
                if (touch_l[0]) begin
                    dir_y  <= 1'b1;
                    ball_y <= ball_y + 10'd1;
                end else if (touch_l[1]) begin
                    dir_y  <= 1'b0;
                    ball_y <= ball_y - 10'd1;
                end else begin                  // Face hit, send it back right
                    dir_x  <= 1'b1;
                    ball_x <= ball_x + 10'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/pong_top.sv
`timescale 1ns/1ps
`default_nettype none

module pong_top #(
    parameter int BALL_PSC    = 1,              // Extra cycles per ball step, ~125874 on board
    parameter int PDL_PSC     = 2,              // Extra cycles per paddle step, ~62937 on board
    parameter int SERVE_DELAY = 20,             // Ball hidden this long, ~50352112 on board
    parameter int SAFE_START  = 8,              // Buttons ignored after reset, ~2500000 on board
    parameter int MAX_SCORE   = 3               // Game ends here, 11 on board
) (
    input  wire                    clk_0,
    input  wire                    rst,
    input  wire                    up_p1,       // Active low buttons
    input  wire                    down_p1,
    input  wire                    up_p2,
    input  wire                    down_p2,
    output pong_geom_pkg::coord_t  ball_x,      // Top left corner of the ball
    output pong_geom_pkg::coord_t  ball_y,
    output pong_geom_pkg::coord_t  pdl1_y,      // Top edge of each paddle
    output pong_geom_pkg::coord_t  pdl2_y,
    output pong_game_pkg::score_t  score_p1,
    output pong_game_pkg::score_t  score_p2,
    output logic                   ball_shown,
    output logic                   game_over,
    output logic                   game_startup
);

    logic any_button;                           // Any of the four pressed
    logic play;
    logic ball_run;
    logic miss_left;
    logic miss_right;

    assign any_button = !up_p1 || !down_p1 || !up_p2 || !down_p2;
    assign ball_shown = ball_run;               // Ball visible exactly while it moves

    game_ctrl #(
        .SERVE_DELAY (SERVE_DELAY),
        .SAFE_START  (SAFE_START),
        .MAX_SCORE   (MAX_SCORE)
    ) i_game_ctrl (
        .clk_0        (clk_0),
        .rst          (rst),
        .any_button   (any_button),
        .miss_left    (miss_left),
        .miss_right   (miss_right),
        .play         (play),
        .ball_run     (ball_run),
        .score_p1     (score_p1),
        .score_p2     (score_p2),
        .game_over    (game_over),
        .game_startup (game_startup)
    );

    paddle_ctrl #(.PDL_PSC(PDL_PSC)) paddle_1 (
        .clk_0 (clk_0),
        .rst   (rst),
        .play  (play),
        .up    (up_p1),
        .down  (down_p1),
        .pdl_y (pdl1_y)
    );

    paddle_ctrl #(.PDL_PSC(PDL_PSC)) paddle_2 (
        .clk_0 (clk_0),
        .rst   (rst),
        .play  (play),
        .up    (up_p2),
        .down  (down_p2),
        .pdl_y (pdl2_y)
    );

    ball_ctrl #(.BALL_PSC(BALL_PSC)) i_ball_ctrl (
        .clk_0      (clk_0),
        .rst        (rst),
        .ball_run   (ball_run),
        .pdl1_y     (pdl1_y),
        .pdl2_y     (pdl2_y),
        .ball_x     (ball_x),
        .ball_y     (ball_y),
        .miss_left  (miss_left),
        .miss_right (miss_right)
    );

endmodule

`default_nettype wire

//--- tb/tb_pong.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pong;

    import pong_geom_pkg::*;
    import pong_game_pkg::*;

    localparam int BALL_PSC    = 1;
    localparam int PDL_PSC     = 2;
    localparam int SERVE_DELAY = 20;
    localparam int SAFE_START  = 8;
    localparam int MAX_SCORE   = 3;
    localparam int STEP        = PDL_PSC + 1;                // Cycles per paddle pixel
    localparam int PDL_HOME    = int'(PDL_HOME_Y);
    localparam int PDL_BOTTOM  = int'(V_VIDEO) - 1 - int'(PDL_HEIGHT);
    localparam int CYCLE_LIMIT = 20000;                      // Six tests of ~2500 cycles, margin

    logic   clk_0;
    logic   rst;
    logic   up_p1;
    logic   down_p1;
    logic   up_p2;
    logic   down_p2;
    coord_t ball_x;
    coord_t ball_y;
    coord_t pdl1_y;
    coord_t pdl2_y;
    score_t score_p1;
    score_t score_p2;
    logic   ball_shown;
    logic   game_over;
    logic   game_startup;

    integer seed = 53;
    int     cycle = 0;                                       // Rising edges so far
    int     cur = 1;                                         // Test that owns new errors
    int     errs [1:6] = '{0, 0, 0, 0, 0, 0};
    string  names [1:6] = '{"reset", "startup", "paddles", "wall bounce and miss",
                            "paddle hit", "game over"};
    int     passed = 0;
    int     failed = 0;
    int     exp1 = 0;                                        // Model scores
    int     exp2 = 0;
    logic   track = 1'b0;                                    // Paddle model compare on
    int     p1_base = PDL_HOME;
    int     p1_dir = 0;
    int     p1_start = 0;
    int     p2_base = PDL_HOME;
    int     p2_dir = 0;
    int     p2_start = 0;

    pong_top #(
        .BALL_PSC    (BALL_PSC),
        .PDL_PSC     (PDL_PSC),
        .SERVE_DELAY (SERVE_DELAY),
        .SAFE_START  (SAFE_START),
        .MAX_SCORE   (MAX_SCORE)
    ) i_pong_top (
        .clk_0        (clk_0),
        .rst          (rst),
        .up_p1        (up_p1),
        .down_p1      (down_p1),
        .up_p2        (up_p2),
        .down_p2      (down_p2),
        .ball_x       (ball_x),
        .ball_y       (ball_y),
        .pdl1_y       (pdl1_y),
        .pdl2_y       (pdl2_y),
        .score_p1     (score_p1),
        .score_p2     (score_p2),
        .ball_shown   (ball_shown),
        .game_over    (game_over),
        .game_startup (game_startup)
    );

    initial begin
        clk_0 = 1'b0;
        forever #5 clk_0 = ~clk_0;                           // 100 MHz
    end

    always @(posedge clk_0) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("Run stopped at the cycle limit of %0d, a wait never ended", CYCLE_LIMIT);
            $display("Something failed");
            $finish;
        end
    end

    task automatic expect_eq(input int id, input string what, input int exp, input int act);
        assert (act == exp) else begin
            $display("[FAIL] %s, %s: expected %0d, actual %0d", names[id], what, exp, act);
            errs[id]++;
        end
    endtask

    task automatic end_test(input int id);
        if (errs[id] == 0) begin
            $display("Test %0d %s: PASS", id, names[id]);
            passed++;
        end else begin
            $display("Test %0d %s: FAIL with %0d errors", id, names[id], errs[id]);
            failed++;
        end
    endtask

    // Paddle top after a hold of one direction, clamped to the screen
    function automatic int paddle_expect(input int base, input int dir, input int start);
        int pos;
        pos = base + dir * ((cycle - start) / STEP);
        if (pos < 0) begin
            pos = 0;
        end else if (pos > PDL_BOTTOM) begin
            pos = PDL_BOTTOM;
        end
        return pos;
    endfunction

    // Next point must go to the given player, the other score holds
    task automatic await_point(input int id, input int scorer);
        while (score_p1 == score_t'(exp1) && score_p2 == score_t'(exp2)) begin
            @(negedge clk_0);
        end
        if (scorer == 1) begin
            exp1++;
        end else begin
            exp2++;
        end
        expect_eq(id, "score_p1", exp1, int'(score_p1));
        expect_eq(id, "score_p2", exp2, int'(score_p2));
    endtask

    always @(negedge clk_0) begin
        if (track) begin
            expect_eq(cur, "pdl1_y", paddle_expect(p1_base, p1_dir, p1_start), int'(pdl1_y));
            expect_eq(cur, "pdl2_y", paddle_expect(p2_base, p2_dir, p2_start), int'(pdl2_y));
        end
    end

    hidden_at_home: assert property (@(negedge clk_0) disable iff (!rst)
        !ball_shown |-> (ball_x == BALL_HOME_X && ball_y == BALL_HOME_Y))
    else begin
        $display("[FAIL] %s, hidden ball: expected (%0d,%0d), actual (%0d,%0d)",
                 names[cur], BALL_HOME_X, BALL_HOME_Y, ball_x, ball_y);
        errs[cur]++;
    end

    over_hides_ball: assert property (@(negedge clk_0) disable iff (!rst)
        game_over |-> !ball_shown)
    else begin
        $display("[FAIL] %s, ball visible during game over: expected 0, actual 1", names[cur]);
        errs[cur]++;
    end

    initial begin
        int gap;
        int n;
        int prev;
        int y0;
        up_p1   = 1'b1;                                      // Buttons released
        down_p1 = 1'b1;
        up_p2   = 1'b1;
        down_p2 = 1'b1;
        rst     = 1'b0;
        repeat (16) @(posedge clk_0);
        @(negedge clk_0);
        rst = 1'b1;
        @(negedge clk_0);
        expect_eq(1, "game_startup", 1, int'(game_startup));
        expect_eq(1, "ball_shown", 0, int'(ball_shown));
        expect_eq(1, "game_over", 0, int'(game_over));
        expect_eq(1, "score_p1", 0, int'(score_p1));
        expect_eq(1, "score_p2", 0, int'(score_p2));
        expect_eq(1, "ball_x", int'(BALL_HOME_X), int'(ball_x));
        expect_eq(1, "ball_y", int'(BALL_HOME_Y), int'(ball_y));
        expect_eq(1, "pdl1_y", PDL_HOME, int'(pdl1_y));
        expect_eq(1, "pdl2_y", PDL_HOME, int'(pdl2_y));
        end_test(1);

        cur = 2;
        gap = 1 + int'($unsigned($random(seed)) % 3);        // Still inside the safety window
        repeat (gap) @(negedge clk_0);
        down_p2 = 1'b0;
        @(negedge clk_0);
        down_p2 = 1'b1;
        repeat (SAFE_START) @(negedge clk_0);
        expect_eq(2, "game_startup after early press", 1, int'(game_startup));
        gap = 1 + int'($unsigned($random(seed)) % 5);
        repeat (gap) @(negedge clk_0);
        down_p2 = 1'b0;
        @(negedge clk_0);                                    // Phase changed on this edge
        down_p2 = 1'b1;
        expect_eq(2, "game_startup after press", 0, int'(game_startup));
        n = 0;
        while (!ball_shown) begin
            @(negedge clk_0);
            n++;
        end
        expect_eq(2, "serve hold cycles", SERVE_DELAY, n);
        end_test(2);

        cur = 4;
        while (ball_y != '0) @(negedge clk_0);
        expect_eq(4, "ball_x at top wall", int'(BALL_HOME_X) - int'(BALL_HOME_Y), int'(ball_x));
        repeat (2) @(negedge clk_0);
        y0 = int'(ball_y);
        repeat (4) @(negedge clk_0);
        expect_eq(4, "ball_y rising after bounce", 1, int'(int'(ball_y) > y0));
        await_point(4, 2);                                   // Left wall, point for p2
        expect_eq(4, "ball_shown after miss", 0, int'(ball_shown));
        expect_eq(4, "ball_x after miss", int'(BALL_HOME_X), int'(ball_x));
        expect_eq(4, "ball_y after miss", int'(BALL_HOME_Y), int'(ball_y));
        end_test(4);

        cur = 3;
        up_p1    = 1'b0;                                     // Paddle 1 climbs to the top
        p1_dir   = -1;
        p1_start = cycle;
        up_p2    = 1'b0;                                     // Paddle 2 has both held
        down_p2  = 1'b0;
        track    = 1'b1;
        repeat (4 * STEP) @(negedge clk_0);
        expect_eq(3, "pdl2_y with both held", PDL_HOME, int'(pdl2_y));
        up_p2    = 1'b1;
        p2_dir   = 1;
        p2_start = cycle;
        while (pdl1_y != '0) @(negedge clk_0);

        cur = 5;
        prev = int'(ball_x);
        @(negedge clk_0);
        while (int'(ball_x) <= prev) begin                   // Ball still heading left
            prev = int'(ball_x);
            @(negedge clk_0);
        end
        expect_eq(5, "turn column within 35..39", 1, int'(prev >= 35 && prev <= 39));
        expect_eq(5, "ball_shown at turn", 1, int'(ball_shown));
        expect_eq(5, "score_p1", exp1, int'(score_p1));
        expect_eq(5, "score_p2", exp2, int'(score_p2));
        up_p1   = 1'b1;                                      // One idle cycle restarts the ticker
        p1_base = 0;
        p1_dir  = 0;
        @(negedge clk_0);
        down_p1  = 1'b0;
        p1_dir   = 1;
        p1_start = cycle;
        end_test(5);

        cur = 3;
        while (int'(pdl2_y) != PDL_BOTTOM) @(negedge clk_0);
        repeat (2 * STEP) @(negedge clk_0);
        expect_eq(3, "pdl2_y held at bottom", PDL_BOTTOM, int'(pdl2_y));
        end_test(3);

        cur = 6;
        while (int'(pdl1_y) != PDL_BOTTOM) @(negedge clk_0);
        down_p1 = 1'b1;                                      // Paddle 1 clear of the ball path
        down_p2 = 1'b1;
        p1_base = PDL_BOTTOM;
        p1_dir  = 0;
        await_point(6, 1);                                   // Rally ends on the right wall
        await_point(6, 2);
        await_point(6, 2);
        track = 1'b0;                                        // Paddles recentre once play ends
        expect_eq(6, "score_p2 at max", MAX_SCORE, int'(score_p2));
        expect_eq(6, "game_over", 1, int'(game_over));
        expect_eq(6, "ball_shown", 0, int'(ball_shown));
        gap = 1 + int'($unsigned($random(seed)) % 8);
        repeat (gap) @(negedge clk_0);
        expect_eq(6, "game_over held", 1, int'(game_over));
        expect_eq(6, "score_p2 kept", MAX_SCORE, int'(score_p2));
        expect_eq(6, "pdl1_y home", PDL_HOME, int'(pdl1_y));
        expect_eq(6, "pdl2_y home", PDL_HOME, int'(pdl2_y));
        up_p2 = 1'b0;
        @(negedge clk_0);
        up_p2 = 1'b1;
        expect_eq(6, "game_over after press", 0, int'(game_over));
        expect_eq(6, "game_startup after press", 0, int'(game_startup));
        expect_eq(6, "score_p1 cleared", 0, int'(score_p1));
        expect_eq(6, "score_p2 cleared", 0, int'(score_p2));
        end_test(6);

        $display("Tests passed: %0d, failed: %0d, errors: %0d", passed, failed,
                 errs[1] + errs[2] + errs[3] + errs[4] + errs[5] + errs[6]);
        if (errs[1] + errs[2] + errs[3] + errs[4] + errs[5] + errs[6] == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- pong.f
hw/pong_geom_pkg.sv
hw/pong_game_pkg.sv
hw/game_ctrl.sv
hw/paddle_ctrl.sv
hw/ball_ctrl.sv
hw/pong_top.sv
tb/tb_pong.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_pong
FILELIST  ?= pong.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee /dev/stderr | grep -F "$(PASS_TEXT)" > /dev/null

clean:
	rm -rf $(BUILD_DIR)
